// ==== pce_cache_pkg.sv ====
//////////////////////////////
// Cache-side types for the P-Mesh cache engine
//////////////////////////////

package pce_cache_pkg;

  localparam int paddr_width_c = 40;
  localparam int dword_width_c = 64;
  localparam int block_width_c = 128;
  localparam int ptag_width_c = 28;
  // Wide enough for the largest set count the engine supports
  localparam int pkt_index_width_c = 8;

  typedef enum logic [2:0] {
    e_miss_load,
    e_miss_store,
    e_uc_load,
    e_uc_store,
    e_wt_store
  } cache_msg_e;

  typedef enum logic [1:0] {
    e_size_1b,
    e_size_2b,
    e_size_4b,
    e_size_8b
  } cache_size_e;

  typedef struct packed {
    cache_msg_e               msg_type;
    cache_size_e              size;
    logic [paddr_width_c-1:0] addr;
    logic [dword_width_c-1:0] data;
  } cache_req_s;

  typedef struct packed {
    logic repl_way;
  } cache_req_meta_s;

  typedef enum logic [1:0] {e_data_mem_write, e_data_mem_uncached} data_mem_op_e;
  typedef enum logic [1:0] {e_tag_mem_set_clear, e_tag_mem_set_tag, e_tag_mem_invalidate} tag_mem_op_e;
  typedef enum logic {e_stat_mem_set_clear} stat_mem_op_e;
  typedef enum logic [1:0] {e_coh_i, e_coh_m} coh_state_e;

  // Which kind of return the control FSM is waiting on
  typedef enum logic [1:0] {e_fill_none, e_fill_block, e_fill_uncached} fill_mode_e;

  typedef struct packed {
    data_mem_op_e                 opcode;
    logic [pkt_index_width_c-1:0] index;
    logic                         way_id;
    logic [block_width_c-1:0]     data;
  } data_mem_pkt_s;

  typedef struct packed {
    tag_mem_op_e                  opcode;
    logic [pkt_index_width_c-1:0] index;
    logic                         way_id;
    logic [ptag_width_c-1:0]      tag;
    coh_state_e                   state;
  } tag_mem_pkt_s;

  typedef struct packed {
    stat_mem_op_e                 opcode;
    logic [pkt_index_width_c-1:0] index;
  } stat_mem_pkt_s;

  // L1.5 is big endian, the core is little endian
  function automatic logic [dword_width_c-1:0] dword_byte_swap(
    input logic [dword_width_c-1:0] d
  );
    logic [dword_width_c-1:0] s;
    for (int i = 0; i < dword_width_c / 8; i++) begin
      s[8*i +: 8] = d[dword_width_c - 8*(i+1) +: 8];
    end
    return s;
  endfunction

endpackage

// ==== pce_l15_pkg.sv ====
//////////////////////////////
// L1.5-side request and return types
//////////////////////////////

package pce_l15_pkg;

  localparam int l15_addr_width_c = 40;
  localparam int l15_data_width_c = 64;
  localparam int l15_inval_index_width_c = 8;
  localparam int l15_inval_pad_width_c = 2*l15_data_width_c - l15_inval_index_width_c - 2;

  typedef enum logic [1:0] {e_load_req, e_store_req} l15_rqtype_e;

  typedef enum logic [2:0] {
    e_l15_size_1b  = 3'b000,
    e_l15_size_2b  = 3'b001,
    e_l15_size_4b  = 3'b010,
    e_l15_size_8b  = 3'b011,
    e_l15_size_16b = 3'b111
  } l15_size_e;

  typedef enum logic [2:0] {
    e_load_ret  = 3'b000,
    e_evict_req = 3'b011,
    e_st_ack    = 3'b100,
    e_int_ret   = 3'b111
  } l15_rtntype_e;

  typedef struct packed {
    l15_rqtype_e                 rqtype;
    logic                        nc;
    l15_size_e                   size;
    logic [l15_addr_width_c-1:0] address;
    logic [1:0]                  l1rplway;
    logic [l15_data_width_c-1:0] data;
  } l15_req_s;

  typedef struct packed {
    logic [l15_data_width_c-1:0] data_1;
    logic [l15_data_width_c-1:0] data_0;
  } l15_ret_data_s;

  typedef struct packed {
    logic [l15_inval_pad_width_c-1:0]   pad;
    logic [l15_inval_index_width_c-1:0] inval_index;
    logic                               inval_way;
    logic                               inval_dcache_inval;
  } l15_ret_inval_s;

  // Load returns carry data, evictions carry the line to invalidate
  typedef union packed {
    l15_ret_data_s  data;
    l15_ret_inval_s inval;
  } l15_ret_payload_u;

  typedef struct packed {
    l15_rtntype_e     rtntype;
    logic             noncacheable;
    l15_ret_payload_u payload;
  } l15_ret_s;

endpackage

// ==== pce_credit_counter.sv ====
//////////////////////////////
// Outstanding L1.5 request counter
//////////////////////////////

`timescale 1ns/1ps

module pce_credit_counter
  #(parameter int max_credits_p = 4)
  (
    input  logic clk_i,
    input  logic reset_i,
    input  logic sent_i,
    input  logic returned_i,
    output logic full_o,
    output logic empty_o
  );

  localparam int count_width_lp = $clog2(max_credits_p + 1);

  logic [count_width_lp-1:0] count_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (sent_i & ~returned_i) begin
      count_r <= count_r + 1'b1;
    end else if (returned_i & ~sent_i) begin
      count_r <= count_r - 1'b1;
    end
  end

  assign full_o = (count_r == count_width_lp'(max_credits_p));
  assign empty_o = (count_r == '0);

endmodule

// ==== pce_req_encoder.sv ====
//////////////////////////////
// Formats cache requests for L1.5
//////////////////////////////

`timescale 1ns/1ps

module pce_req_encoder
  import pce_cache_pkg::*;
  import pce_l15_pkg::*;
  (
    input  cache_req_s      req_i,
    input  cache_req_meta_s meta_i,
    output l15_req_s        l15_req_o
  );

  logic       is_store;
  logic [2:0] byte_mask;
  l15_size_e  size_l15;

  assign is_store = req_i.msg_type inside {e_uc_store, e_wt_store};

  always_comb begin
    case (req_i.size)
      e_size_1b: size_l15 = e_l15_size_1b;
      e_size_2b: size_l15 = e_l15_size_2b;
      e_size_4b: size_l15 = e_l15_size_4b;
      default:   size_l15 = e_l15_size_8b;
    endcase
  end

  // Low byte mask within one replicated chunk
  assign byte_mask = 3'((4'd1 << req_i.size) - 4'd1);

  always_comb begin
    logic [2:0] src;
    l15_req_o = '0;
    l15_req_o.address = req_i.addr;
    l15_req_o.l1rplway = {req_i.addr[11], meta_i.repl_way};

    case (req_i.msg_type)
      e_uc_store, e_wt_store: begin
        l15_req_o.rqtype = e_store_req;
        l15_req_o.nc = (req_i.msg_type == e_uc_store);
        l15_req_o.size = size_l15;
      end
      e_uc_load: begin
        l15_req_o.rqtype = e_load_req;
        l15_req_o.nc = 1'b1;
        l15_req_o.size = size_l15;
      end
      default: begin
        l15_req_o.rqtype = e_load_req;
        l15_req_o.nc = 1'b0;
        l15_req_o.size = e_l15_size_16b;
      end
    endcase

    // Byte-reverse the valid bytes and repeat them across the dword
    if (is_store) begin
      for (int i = 0; i < 8; i++) begin
        src = 3'(~i) & byte_mask;
        l15_req_o.data[8*i +: 8] = req_i.data[8*src +: 8];
      end
    end
  end

endmodule

// ==== pce_ret_decoder.sv ====
//////////////////////////////
// Turns L1.5 returns into cache packets
//////////////////////////////

`timescale 1ns/1ps

module pce_ret_decoder
  import pce_cache_pkg::*;
  import pce_l15_pkg::*;
  #(parameter int sets_p = 128,
    parameter int assoc_p = 2)
  (
    input  l15_ret_s        ret_i,
    input  cache_req_s      req_r_i,
    input  cache_req_meta_s meta_r_i,
    input  fill_mode_e      fill_mode_i,
    output data_mem_pkt_s   data_pkt_o,
    output tag_mem_pkt_s    tag_pkt_o,
    output stat_mem_pkt_s   stat_pkt_o,
    output logic            inval_v_o,
    output logic            fill_match_o
  );

  // The block is split into one bank per way
  localparam int bank_bytes_lp = block_width_c / assoc_p / 8;
  localparam int block_offset_lp = $clog2(bank_bytes_lp) + $clog2(assoc_p);
  localparam int index_width_lp = $clog2(sets_p);

  l15_ret_payload_u             payload;
  logic [pkt_index_width_c-1:0] fill_index;
  logic [dword_width_c-1:0]     dword_0_swap, dword_1_swap;
  logic                         is_load_ret, is_evict;

  assign payload = ret_i.payload;
  assign fill_index = pkt_index_width_c'(req_r_i.addr[block_offset_lp +: index_width_lp]);
  assign dword_0_swap = dword_byte_swap(payload.data.data_0);
  assign dword_1_swap = dword_byte_swap(payload.data.data_1);

  assign is_load_ret = (ret_i.rtntype == e_load_ret);
  assign is_evict = (ret_i.rtntype == e_evict_req);
  assign inval_v_o = is_evict & payload.inval.inval_dcache_inval;
  assign fill_match_o = is_load_ret
                      & (((fill_mode_i == e_fill_block) & ~ret_i.noncacheable)
                        | ((fill_mode_i == e_fill_uncached) & ret_i.noncacheable));

  always_comb begin
    data_pkt_o.index = fill_index;
    data_pkt_o.way_id = meta_r_i.repl_way;
    if (fill_mode_i == e_fill_uncached) begin
      data_pkt_o.opcode = e_data_mem_uncached;
      data_pkt_o.data = {{dword_width_c{1'b0}}, req_r_i.addr[3] ? dword_1_swap : dword_0_swap};
    end else begin
      data_pkt_o.opcode = e_data_mem_write;
      data_pkt_o.data = {dword_1_swap, dword_0_swap};
    end
  end

  always_comb begin
    if (is_evict) begin
      tag_pkt_o.opcode = e_tag_mem_invalidate;
      tag_pkt_o.index = payload.inval.inval_index;
      tag_pkt_o.way_id = payload.inval.inval_way;
      tag_pkt_o.tag = '0;
      tag_pkt_o.state = e_coh_i;
    end else begin
      tag_pkt_o.opcode = e_tag_mem_set_tag;
      tag_pkt_o.index = fill_index;
      tag_pkt_o.way_id = meta_r_i.repl_way;
      tag_pkt_o.tag = req_r_i.addr[block_offset_lp + index_width_lp +: ptag_width_c];
      tag_pkt_o.state = e_coh_m;
    end
  end

  assign stat_pkt_o.opcode = e_stat_mem_set_clear;
  assign stat_pkt_o.index = is_evict ? payload.inval.inval_index : fill_index;

endmodule

// ==== pce_ctrl.sv ====
//////////////////////////////
// Cache engine control FSM
// Sequences reset sweep, requests and returns
//////////////////////////////

`timescale 1ns/1ps

module pce_ctrl
  import pce_cache_pkg::*;
  import pce_l15_pkg::*;
  #(parameter int sets_p = 128)
  (
    input  logic            clk_i,
    input  logic            reset_i,

    input  cache_req_s      cache_req_i,
    input  logic            cache_req_v_i,
    output logic            cache_req_ready_o,
    input  cache_req_meta_s cache_req_meta_i,
    input  logic            cache_req_meta_v_i,
    output logic            cache_req_complete_o,

    output data_mem_pkt_s   data_pkt_o,
    output logic            data_pkt_v_o,
    input  logic            data_pkt_yumi_i,
    output tag_mem_pkt_s    tag_pkt_o,
    output logic            tag_pkt_v_o,
    input  logic            tag_pkt_yumi_i,
    output stat_mem_pkt_s   stat_pkt_o,
    output logic            stat_pkt_v_o,
    input  logic            stat_pkt_yumi_i,

    output l15_req_s        l15_req_o,
    output logic            l15_req_v_o,
    input  logic            l15_req_ready_i,
    input  l15_ret_s        l15_ret_i,
    input  logic            l15_ret_v_i,
    output logic            l15_ret_yumi_o,

    input  l15_req_s        enc_req_i,
    output cache_req_s      enc_src_o,
    output cache_req_s      req_r_o,
    output cache_req_meta_s meta_r_o,
    output fill_mode_e      fill_mode_o,
    input  tag_mem_pkt_s    dec_tag_pkt_i,
    input  data_mem_pkt_s   dec_data_pkt_i,
    input  stat_mem_pkt_s   dec_stat_pkt_i,
    input  logic            dec_inval_v_i,
    input  logic            dec_fill_match_i
  );

  localparam int index_width_lp = $clog2(sets_p);

  typedef enum logic [2:0] {
    e_reset, e_clear, e_ready, e_send_req, e_read_wait, e_uc_read_wait
  } state_e;

  state_e                    state_r, state_n;
  cache_req_s                req_r;
  cache_req_meta_s           meta_r;
  logic [index_width_lp-1:0] index_cnt_r;
  logic                      index_up, index_done;
  logic                      store_v, inval_v;
  tag_mem_pkt_s              sweep_tag_pkt;
  stat_mem_pkt_s             sweep_stat_pkt;

  assign index_done = (index_cnt_r == index_width_lp'(sets_p - 1));
  assign store_v = cache_req_v_i & (cache_req_i.msg_type inside {e_uc_store, e_wt_store});
  assign inval_v = l15_ret_v_i & dec_inval_v_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_reset;
      index_cnt_r <= '0;
    end else begin
      state_r <= state_n;
      if (index_up) begin
        index_cnt_r <= index_done ? '0 : index_cnt_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cache_req_v_i & cache_req_ready_o) begin
      req_r <= cache_req_i;
    end
    if (cache_req_meta_v_i) begin
      meta_r <= cache_req_meta_i;
    end
  end

  always_comb begin
    sweep_tag_pkt = '0;
    sweep_tag_pkt.opcode = e_tag_mem_set_clear;
    sweep_tag_pkt.index = pkt_index_width_c'(index_cnt_r);
    sweep_stat_pkt.opcode = e_stat_mem_set_clear;
    sweep_stat_pkt.index = pkt_index_width_c'(index_cnt_r);
  end

  always_comb begin
    state_n = state_r;
    cache_req_ready_o = 1'b0;
    cache_req_complete_o = 1'b0;
    data_pkt_v_o = 1'b0;
    tag_pkt_v_o = 1'b0;
    stat_pkt_v_o = 1'b0;
    l15_req_v_o = 1'b0;
    l15_ret_yumi_o = 1'b0;
    index_up = 1'b0;

    unique case (state_r)
      e_reset: begin
        l15_ret_yumi_o = l15_ret_v_i & (l15_ret_i.rtntype == e_int_ret);
        if (l15_ret_yumi_o) state_n = e_clear;
      end
      e_clear: begin
        tag_pkt_v_o = 1'b1;
        stat_pkt_v_o = 1'b1;
        // An eviction borrows the tag port, so the sweep stalls for it
        index_up = tag_pkt_yumi_i & stat_pkt_yumi_i & ~inval_v;
        cache_req_complete_o = index_up & index_done;
        if (cache_req_complete_o) state_n = e_ready;
      end
      e_ready: begin
        cache_req_ready_o = l15_req_ready_i;
        if (store_v) begin
          l15_req_v_o = l15_req_ready_i;
        end else if (cache_req_v_i & l15_req_ready_i) begin
          state_n = e_send_req;
        end
      end
      e_send_req: begin
        l15_req_v_o = l15_req_ready_i;
        if (l15_req_v_o) begin
          state_n = (req_r.msg_type == e_uc_load) ? e_uc_read_wait : e_read_wait;
        end
      end
      e_read_wait: begin
        if (l15_ret_v_i & dec_fill_match_i) begin
          data_pkt_v_o = 1'b1;
          tag_pkt_v_o = 1'b1;
          l15_ret_yumi_o = data_pkt_yumi_i & tag_pkt_yumi_i;
          cache_req_complete_o = l15_ret_yumi_o;
          if (cache_req_complete_o) state_n = e_ready;
        end
      end
      e_uc_read_wait: begin
        if (l15_ret_v_i & dec_fill_match_i) begin
          data_pkt_v_o = 1'b1;
          l15_ret_yumi_o = data_pkt_yumi_i;
          cache_req_complete_o = l15_ret_yumi_o;
          if (cache_req_complete_o) state_n = e_ready;
        end
      end
      default: state_n = e_reset;
    endcase

    // Evictions and store acks can show up in any state once out of reset
    if (state_r != e_reset && l15_ret_v_i) begin
      if (inval_v) begin
        tag_pkt_v_o = 1'b1;
        l15_ret_yumi_o = tag_pkt_yumi_i;
      end else if (l15_ret_i.rtntype inside {e_st_ack, e_evict_req}) begin
        l15_ret_yumi_o = 1'b1;
      end
    end
  end

  assign tag_pkt_o = (state_r == e_clear && !inval_v) ? sweep_tag_pkt : dec_tag_pkt_i;
  assign stat_pkt_o = (state_r == e_clear) ? sweep_stat_pkt : dec_stat_pkt_i;
  assign data_pkt_o = dec_data_pkt_i;

  assign enc_src_o = (state_r == e_ready) ? cache_req_i : req_r;
  assign l15_req_o = enc_req_i;
  assign req_r_o = req_r;
  assign meta_r_o = meta_r;

  always_comb begin
    unique case (state_r)
      e_read_wait:    fill_mode_o = e_fill_block;
      e_uc_read_wait: fill_mode_o = e_fill_uncached;
      default:        fill_mode_o = e_fill_none;
    endcase
  end

endmodule

// ==== pce_top.sv ====
//////////////////////////////
// P-Mesh cache engine, D$ side
//////////////////////////////

`timescale 1ns/1ps

module pce_top
  import pce_cache_pkg::*;
  import pce_l15_pkg::*;
  #(parameter int sets_p = 128,
    parameter int assoc_p = 2,
    parameter int max_credits_p = 4)
  (
    input  logic            clk_i,
    input  logic            reset_i,

    input  cache_req_s      cache_req_i,
    input  logic            cache_req_v_i,
    output logic            cache_req_ready_o,
    input  cache_req_meta_s cache_req_meta_i,
    input  logic            cache_req_meta_v_i,
    output logic            cache_req_complete_o,

    output data_mem_pkt_s   data_pkt_o,
    output logic            data_pkt_v_o,
    input  logic            data_pkt_yumi_i,
    output tag_mem_pkt_s    tag_pkt_o,
    output logic            tag_pkt_v_o,
    input  logic            tag_pkt_yumi_i,
    output stat_mem_pkt_s   stat_pkt_o,
    output logic            stat_pkt_v_o,
    input  logic            stat_pkt_yumi_i,

    output l15_req_s        l15_req_o,
    output logic            l15_req_v_o,
    input  logic            l15_req_ready_i,
    input  l15_ret_s        l15_ret_i,
    input  logic            l15_ret_v_i,
    output logic            l15_ret_yumi_o,

    output logic            credits_full_o,
    output logic            credits_empty_o
  );

  l15_req_s        enc_req;
  cache_req_s      enc_src, req_r;
  cache_req_meta_s meta_r;
  fill_mode_e      fill_mode;
  data_mem_pkt_s   dec_data_pkt;
  tag_mem_pkt_s    dec_tag_pkt;
  stat_mem_pkt_s   dec_stat_pkt;
  logic            dec_inval_v, dec_fill_match;
  logic            credit_returned;

  // Interrupt and evict returns never held a credit
  assign credit_returned = l15_ret_yumi_o & ~(l15_ret_i.rtntype inside {e_int_ret, e_evict_req});

  pce_ctrl #(.sets_p(sets_p)) pce_ctrl_inst (
    .clk_i, .reset_i,
    .cache_req_i, .cache_req_v_i, .cache_req_ready_o,
    .cache_req_meta_i, .cache_req_meta_v_i, .cache_req_complete_o,
    .data_pkt_o, .data_pkt_v_o, .data_pkt_yumi_i,
    .tag_pkt_o, .tag_pkt_v_o, .tag_pkt_yumi_i,
    .stat_pkt_o, .stat_pkt_v_o, .stat_pkt_yumi_i,
    .l15_req_o, .l15_req_v_o, .l15_req_ready_i,
    .l15_ret_i, .l15_ret_v_i, .l15_ret_yumi_o,
    .enc_req_i(enc_req),
    .enc_src_o(enc_src),
    .req_r_o(req_r),
    .meta_r_o(meta_r),
    .fill_mode_o(fill_mode),
    .dec_tag_pkt_i(dec_tag_pkt),
    .dec_data_pkt_i(dec_data_pkt),
    .dec_stat_pkt_i(dec_stat_pkt),
    .dec_inval_v_i(dec_inval_v),
    .dec_fill_match_i(dec_fill_match)
  );

  pce_req_encoder pce_req_encoder_inst (
    .req_i(enc_src),
    .meta_i(meta_r),
    .l15_req_o(enc_req)
  );

  pce_ret_decoder #(.sets_p(sets_p), .assoc_p(assoc_p)) pce_ret_decoder_inst (
    .ret_i(l15_ret_i),
    .req_r_i(req_r),
    .meta_r_i(meta_r),
    .fill_mode_i(fill_mode),
    .data_pkt_o(dec_data_pkt),
    .tag_pkt_o(dec_tag_pkt),
    .stat_pkt_o(dec_stat_pkt),
    .inval_v_o(dec_inval_v),
    .fill_match_o(dec_fill_match)
  );

  pce_credit_counter #(.max_credits_p(max_credits_p)) pce_credit_counter_inst (
    .clk_i, .reset_i,
    .sent_i(l15_req_v_o),
    .returned_i(credit_returned),
    .full_o(credits_full_o),
    .empty_o(credits_empty_o)
  );

endmodule

// ==== pce_tb.sv ====
//////////////////////////////
// Testbench for the P-Mesh cache engine
//////////////////////////////

`timescale 1ns/1ps

module pce_tb
  import pce_cache_pkg::*;
  import pce_l15_pkg::*;
  ();

  localparam int sets_c = 128;
  localparam int assoc_c = 2;
  localparam int max_credits_c = 4;
  // A fill line is 16 bytes, so the set index starts at bit 4
  localparam int offset_bits_c = 4;
  localparam int index_bits_c = $clog2(sets_c);
  localparam int timeout_c = 200;
  localparam int sweep_timeout_c = 20 * sets_c;

  logic            clk_i, reset_i;
  cache_req_s      cache_req_i;
  logic            cache_req_v_i, cache_req_ready_o;
  cache_req_meta_s cache_req_meta_i;
  logic            cache_req_meta_v_i, cache_req_complete_o;
  data_mem_pkt_s   data_pkt_o;
  logic            data_pkt_v_o, data_pkt_yumi_i;
  tag_mem_pkt_s    tag_pkt_o;
  logic            tag_pkt_v_o, tag_pkt_yumi_i;
  stat_mem_pkt_s   stat_pkt_o;
  logic            stat_pkt_v_o, stat_pkt_yumi_i;
  l15_req_s        l15_req_o;
  logic            l15_req_v_o, l15_req_ready_i;
  l15_ret_s        l15_ret_i;
  logic            l15_ret_v_i, l15_ret_yumi_o;
  logic            credits_full_o, credits_empty_o;

  integer seed;
  int     credit_count;
  int     pending_acks;

  pce_top #(.sets_p(sets_c), .assoc_p(assoc_c), .max_credits_p(max_credits_c)) pce_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [255:0] actual,
                             input logic [255:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic logic [63:0] reverse_bytes(input logic [63:0] d);
    logic [63:0] r;
    for (int i = 0; i < 8; i++) begin
      r[8*i +: 8] = d[8*(7-i) +: 8];
    end
    return r;
  endfunction

  // Reverse the low bytes of the store and repeat them over the dword
  function automatic logic [63:0] store_data_model(input logic [63:0] d, input int nbytes);
    logic [63:0] r;
    for (int i = 0; i < 8; i++) begin
      r[8*i +: 8] = d[8*(nbytes - 1 - i % nbytes) +: 8];
    end
    return r;
  endfunction

  function automatic l15_size_e l15_size_model(input cache_size_e s);
    case (s)
      e_size_1b: return e_l15_size_1b;
      e_size_2b: return e_l15_size_2b;
      e_size_4b: return e_l15_size_4b;
      default:   return e_l15_size_8b;
    endcase
  endfunction

  // Every cycle starts at the rising edge, with fresh random back-pressure
  task automatic advance();
    @(posedge clk_i);
    data_pkt_yumi_i <= ($random(seed) & 3) != 0;
    tag_pkt_yumi_i <= ($random(seed) & 3) != 0;
    stat_pkt_yumi_i <= ($random(seed) & 3) != 0;
    l15_req_ready_i <= ($random(seed) & 1) != 0;
  endtask

  task automatic settle();
    @(negedge clk_i);
  endtask

  // Credit model, compared after every cycle
  always @(negedge clk_i) begin
    if (reset_i) begin
      credit_count = 0;
    end else begin
      check_value("credits_full_o", 256'(credits_full_o), 256'(credit_count == max_credits_c));
      check_value("credits_empty_o", 256'(credits_empty_o), 256'(credit_count == 0));
      if (l15_req_v_o && !l15_req_ready_i) begin
        fail_run("L1.5 request raised while L1.5 was not ready");
      end
      if (l15_req_v_o && l15_req_ready_i) begin
        credit_count++;
      end
      if (l15_ret_v_i && l15_ret_yumi_o &&
          !(l15_ret_i.rtntype inside {e_int_ret, e_evict_req})) begin
        credit_count--;
      end
    end
  end

  task automatic check_idle();
    check_value("cache_req_ready_o", 256'(cache_req_ready_o), 256'(0));
    check_value("cache_req_complete_o", 256'(cache_req_complete_o), 256'(0));
    check_value("data_pkt_v_o", 256'(data_pkt_v_o), 256'(0));
    check_value("tag_pkt_v_o", 256'(tag_pkt_v_o), 256'(0));
    check_value("stat_pkt_v_o", 256'(stat_pkt_v_o), 256'(0));
    check_value("l15_req_v_o", 256'(l15_req_v_o), 256'(0));
    check_value("l15_ret_yumi_o", 256'(l15_ret_yumi_o), 256'(0));
  endtask

  task automatic run_sweep();
    l15_ret_s      ret;
    tag_mem_pkt_s  exp_tag;
    stat_mem_pkt_s exp_stat;
    logic [7:0]    expect_index;
    logic          done;
    int            cycles;
    ret = '0;
    ret.rtntype = e_int_ret;
    advance();
    l15_ret_i <= ret;
    l15_ret_v_i <= 1'b1;
    settle();
    check_value("l15_ret_yumi_o", 256'(l15_ret_yumi_o), 256'(1));
    advance();
    l15_ret_v_i <= 1'b0;
    expect_index = '0;
    done = 1'b0;
    cycles = 0;
    while (!done) begin
      settle();
      exp_tag = '0;
      exp_tag.opcode = e_tag_mem_set_clear;
      exp_tag.index = expect_index;
      exp_stat.opcode = e_stat_mem_set_clear;
      exp_stat.index = expect_index;
      check_value("tag_pkt_v_o", 256'(tag_pkt_v_o), 256'(1));
      check_value("stat_pkt_v_o", 256'(stat_pkt_v_o), 256'(1));
      check_value("tag_pkt_o", 256'(tag_pkt_o), 256'(exp_tag));
      check_value("stat_pkt_o", 256'(stat_pkt_o), 256'(exp_stat));
      if (tag_pkt_yumi_i && stat_pkt_yumi_i) begin
        done = (expect_index == 8'(sets_c - 1));
        expect_index = expect_index + 1'b1;
      end
      check_value("cache_req_complete_o", 256'(cache_req_complete_o), 256'(done));
      cycles = cycles + 1;
      if (!done && cycles > sweep_timeout_c) begin
        fail_run("timeout waiting for the clear sweep to finish");
      end
      advance();
    end
    settle();
    check_value("cache_req_complete_o", 256'(cache_req_complete_o), 256'(0));
    check_value("tag_pkt_v_o", 256'(tag_pkt_v_o), 256'(0));
    check_value("cache_req_ready_o", 256'(cache_req_ready_o), 256'(l15_req_ready_i));
  endtask

  task automatic do_store();
    cache_req_s  req;
    logic [63:0] r;
    int          nbytes;
    r = rand64();
    req.msg_type = r[0] ? e_uc_store : e_wt_store;
    req.size = cache_size_e'(r[2:1]);
    nbytes = 1 << req.size;
    r = rand64();
    req.addr = r[39:0];
    req.data = rand64();
    advance();
    cache_req_i <= req;
    cache_req_v_i <= 1'b1;
    l15_req_ready_i <= 1'b1;
    settle();
    check_value("cache_req_ready_o", 256'(cache_req_ready_o), 256'(1));
    check_value("l15_req_v_o", 256'(l15_req_v_o), 256'(1));
    check_value("cache_req_complete_o", 256'(cache_req_complete_o), 256'(0));
    check_value("l15_req_o.rqtype", 256'(l15_req_o.rqtype), 256'(e_store_req));
    check_value("l15_req_o.nc", 256'(l15_req_o.nc), 256'(req.msg_type == e_uc_store));
    check_value("l15_req_o.size", 256'(l15_req_o.size), 256'(l15_size_model(req.size)));
    check_value("l15_req_o.address", 256'(l15_req_o.address), 256'(req.addr));
    check_value("l15_req_o.data", 256'(l15_req_o.data), 256'(store_data_model(req.data, nbytes)));
    advance();
    cache_req_v_i <= 1'b0;
    pending_acks++;
  endtask

  task automatic send_store_ack();
    l15_ret_s ret;
    ret = '0;
    ret.rtntype = e_st_ack;
    ret.payload.data.data_0 = rand64();
    advance();
    l15_ret_i <= ret;
    l15_ret_v_i <= 1'b1;
    settle();
    check_value("l15_ret_yumi_o", 256'(l15_ret_yumi_o), 256'(1));
    check_value("cache_req_complete_o", 256'(cache_req_complete_o), 256'(0));
    advance();
    l15_ret_v_i <= 1'b0;
    pending_acks--;
  endtask

  task automatic send_evict();
    l15_ret_s     ret;
    tag_mem_pkt_s exp_tag;
    logic [63:0]  r;
    logic         taken;
    int           cycles;
    r = rand64();
    ret = '0;
    ret.rtntype = e_evict_req;
    ret.payload.data.data_1 = rand64();
    ret.payload.data.data_0 = r;
    ret.payload.inval.inval_index = r[15:8];
    ret.payload.inval.inval_way = r[16];
    ret.payload.inval.inval_dcache_inval = 1'b1;
    exp_tag = '0;
    exp_tag.opcode = e_tag_mem_invalidate;
    exp_tag.index = r[15:8];
    exp_tag.way_id = r[16];
    exp_tag.state = e_coh_i;
    advance();
    l15_ret_i <= ret;
    l15_ret_v_i <= 1'b1;
    taken = 1'b0;
    cycles = 0;
    while (!taken) begin
      settle();
      check_value("tag_pkt_v_o", 256'(tag_pkt_v_o), 256'(1));
      check_value("tag_pkt_o", 256'(tag_pkt_o), 256'(exp_tag));
      check_value("data_pkt_v_o", 256'(data_pkt_v_o), 256'(0));
      check_value("cache_req_complete_o", 256'(cache_req_complete_o), 256'(0));
      check_value("l15_ret_yumi_o", 256'(l15_ret_yumi_o), 256'(tag_pkt_yumi_i));
      taken = tag_pkt_yumi_i;
      cycles = cycles + 1;
      if (!taken && cycles > timeout_c) begin
        fail_run("timeout waiting for the eviction to be consumed");
      end
      advance();
    end
    l15_ret_v_i <= 1'b0;
  endtask

  task automatic do_load(input logic uncached, input logic evict_first);
    cache_req_s      req;
    cache_req_meta_s meta;
    l15_req_s        exp_req;
    l15_ret_s        ret;
    data_mem_pkt_s   exp_data;
    tag_mem_pkt_s    exp_tag;
    logic [63:0]     r, d0, d1;
    logic [7:0]      index;
    logic            done;
    logic            exp_yumi;
    int              cycles;
    r = rand64();
    req.msg_type = uncached ? e_uc_load : e_miss_load;
    req.size = cache_size_e'(r[1:0]);
    meta.repl_way = r[2];
    r = rand64();
    req.addr = r[39:0];
    req.data = rand64();
    index = 8'(req.addr[offset_bits_c +: index_bits_c]);
    exp_req = '0;
    exp_req.rqtype = e_load_req;
    exp_req.nc = uncached;
    exp_req.size = uncached ? l15_size_model(req.size) : e_l15_size_16b;
    exp_req.address = req.addr;
    exp_req.l1rplway = {req.addr[11], meta.repl_way};
    advance();
    cache_req_i <= req;
    cache_req_v_i <= 1'b1;
    cache_req_meta_i <= meta;
    cache_req_meta_v_i <= 1'b1;
    l15_req_ready_i <= 1'b1;
    settle();
    check_value("cache_req_ready_o", 256'(cache_req_ready_o), 256'(1));
    check_value("l15_req_v_o", 256'(l15_req_v_o), 256'(0));
    advance();
    cache_req_v_i <= 1'b0;
    cache_req_meta_v_i <= 1'b0;
    done = 1'b0;
    cycles = 0;
    while (!done) begin
      settle();
      if (l15_req_v_o) begin
        check_value("l15_req_o", 256'(l15_req_o), 256'(exp_req));
        done = 1'b1;
      end
      cycles = cycles + 1;
      if (!done && cycles > timeout_c) begin
        fail_run("timeout waiting for the L1.5 load request");
      end
      advance();
    end
    if (evict_first) begin
      send_evict();
    end

    d0 = rand64();
    d1 = rand64();
    ret = '0;
    ret.rtntype = e_load_ret;
    ret.noncacheable = uncached;
    ret.payload.data.data_0 = d0;
    ret.payload.data.data_1 = d1;
    exp_data.index = index;
    exp_data.way_id = meta.repl_way;
    if (uncached) begin
      exp_data.opcode = e_data_mem_uncached;
      exp_data.data = {64'h0, req.addr[3] ? reverse_bytes(d1) : reverse_bytes(d0)};
    end else begin
      exp_data.opcode = e_data_mem_write;
      exp_data.data = {reverse_bytes(d1), reverse_bytes(d0)};
    end
    exp_tag.opcode = e_tag_mem_set_tag;
    exp_tag.index = index;
    exp_tag.way_id = meta.repl_way;
    exp_tag.tag = req.addr[offset_bits_c + index_bits_c +: ptag_width_c];
    exp_tag.state = e_coh_m;

    advance();
    l15_ret_i <= ret;
    l15_ret_v_i <= 1'b1;
    done = 1'b0;
    cycles = 0;
    while (!done) begin
      settle();
      exp_yumi = data_pkt_yumi_i && (uncached || tag_pkt_yumi_i);
      check_value("data_pkt_v_o", 256'(data_pkt_v_o), 256'(1));
      check_value("tag_pkt_v_o", 256'(tag_pkt_v_o), 256'(!uncached));
      check_value("data_pkt_o", 256'(data_pkt_o), 256'(exp_data));
      if (!uncached) begin
        check_value("tag_pkt_o", 256'(tag_pkt_o), 256'(exp_tag));
      end
      check_value("l15_ret_yumi_o", 256'(l15_ret_yumi_o), 256'(exp_yumi));
      check_value("cache_req_complete_o", 256'(cache_req_complete_o), 256'(exp_yumi));
      done = exp_yumi;
      cycles = cycles + 1;
      if (!done && cycles > timeout_c) begin
        fail_run("timeout waiting for the load return to be consumed");
      end
      advance();
    end
    l15_ret_v_i <= 1'b0;
  endtask

  initial begin
    logic [63:0] r;
    seed = 32'he980c54e;
    pending_acks = 0;
    reset_i <= 1'b1;
    cache_req_i <= '0;
    cache_req_v_i <= 1'b0;
    cache_req_meta_i <= '0;
    cache_req_meta_v_i <= 1'b0;
    data_pkt_yumi_i <= 1'b0;
    tag_pkt_yumi_i <= 1'b0;
    stat_pkt_yumi_i <= 1'b0;
    l15_req_ready_i <= 1'b0;
    l15_ret_i <= '0;
    l15_ret_v_i <= 1'b0;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    settle();
    check_idle();

    run_sweep();

    for (int n = 0; n < 40; n++) begin
      if (pending_acks == max_credits_c || (pending_acks > 0 && ($random(seed) & 1) != 0)) begin
        send_store_ack();
      end
      do_store();
    end
    while (pending_acks > 0) begin
      send_store_ack();
    end

    for (int n = 0; n < 40; n++) begin
      r = rand64();
      if (r[0]) begin
        send_evict();
      end
      do_load(r[1], r[2]);
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== list.f ====
pce_cache_pkg.sv
pce_l15_pkg.sv
pce_credit_counter.sv
pce_req_encoder.sv
pce_ret_decoder.sv
pce_ctrl.sv
pce_top.sv
pce_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := pce_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
